// ==== acc_ctrl_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module acc_ctrl_regs #(
  parameter int DATA_W = 16,
  parameter int ADDR_W = 6
) (
  input  wire logic                  clk,
  input  wire logic                  rst_i,
  input  wire logic [11:0]           awaddr_i,
  input  wire logic                  awvalid_i,
  output logic                       awready_o,
  input  wire logic [31:0]           wdata_i,
  input  wire logic [3:0]            wstrb_i,
  input  wire logic                  wvalid_i,
  output logic                       wready_o,
  output logic      [1:0]            bresp_o,
  output logic                       bvalid_o,
  input  wire logic                  bready_i,
  input  wire logic [11:0]           araddr_i,
  input  wire logic                  arvalid_i,
  output logic                       arready_o,
  output logic      [31:0]           rdata_o,
  output logic      [1:0]            rresp_o,
  output logic                       rvalid_o,
  input  wire logic                  rready_i,
  input  wire logic                  done_i,
  output conv_acc_pkg::conv_acc_mode_t mode_o,
  output logic                       start_o,
  output logic      [DATA_W-1:0]     weight_o,
  output logic      [DATA_W-1:0]     bias_o,
  output logic                       host_cs_o,
  output logic                       host_we_o,
  output logic                       host_sel_out_o,
  output logic      [ADDR_W-1:0]     host_addr_o,
  output logic      [DATA_W-1:0]     host_wdata_o,
  input  wire logic [DATA_W-1:0]     host_rdata_i
);

  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;

  logic [11:0] wr_addr;
  logic [11:0] rd_addr;
  logic [31:0] wr_data;
  logic [31:0] wmask;
  logic [31:0] reg_rdata;
  logic [1:0]  wr_pend;  // Write stages after the AW/W handshake
  logic        rd_pend;
  logic        rd_wait;
  logic        rd_err;
  logic        busy;
  logic        done;
  logic        port_free;
  logic        wr_go;
  logic        rd_go;
  logic        wr_in, wr_out, wr_mem;
  logic        rd_in, rd_out, rd_mem;
  logic        start_ok;

  assign wr_in  = (wr_addr[11:8] == conv_acc_pkg::IN_BASE[11:8]);
  assign wr_out = (wr_addr[11:8] == conv_acc_pkg::OUT_BASE[11:8]);
  assign wr_mem = wr_in || wr_out;
  assign rd_in  = (rd_addr[11:8] == conv_acc_pkg::IN_BASE[11:8]);
  assign rd_out = (rd_addr[11:8] == conv_acc_pkg::OUT_BASE[11:8]);
  assign rd_mem = rd_in || rd_out;

  assign wmask = {{8{wstrb_i[3]}}, {8{wstrb_i[2]}}, {8{wstrb_i[1]}}, {8{wstrb_i[0]}}};

  // Host port carries one access at a time
  assign port_free = !awready_o && !arready_o && (wr_pend == 2'b00) && !rd_pend && !rd_wait;
  assign wr_go     = awvalid_i && wvalid_i && !bvalid_o && port_free;
  assign rd_go     = arvalid_i && !rvalid_o && port_free && !wr_go;

  assign start_ok = wr_data[0] && ((wr_data[2:1] == conv_acc_pkg::MODE_CONV_1X1) ||
                                   (wr_data[2:1] == conv_acc_pkg::MODE_MAX_POOL));

  assign host_cs_o      = ((wr_pend[0] && wr_mem) || (rd_pend && rd_mem)) && !busy;
  assign host_we_o      = wr_pend[0];
  assign host_sel_out_o = wr_pend[0] ? wr_out : rd_out;
  assign host_addr_o    = wr_pend[0] ? wr_addr[ADDR_W+1:2] : rd_addr[ADDR_W+1:2];
  assign host_wdata_o   = wr_data[DATA_W-1:0];

  always_comb begin
    reg_rdata = '0;
    case (rd_addr)
      conv_acc_pkg::REG_CTRL:   reg_rdata[2:1] = mode_o;
      conv_acc_pkg::REG_STATUS: reg_rdata[1:0] = {done, busy};
      conv_acc_pkg::REG_WEIGHT: reg_rdata[DATA_W-1:0] = weight_o;
      conv_acc_pkg::REG_BIAS:   reg_rdata[DATA_W-1:0] = bias_o;
      default: ;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst_i) begin
      awready_o <= 1'b0;
      wready_o  <= 1'b0;
      arready_o <= 1'b0;
      bvalid_o  <= 1'b0;
      rvalid_o  <= 1'b0;
      wr_pend   <= 2'b00;
      rd_pend   <= 1'b0;
      rd_wait   <= 1'b0;
      busy      <= 1'b0;
      done      <= 1'b0;
      start_o   <= 1'b0;
      mode_o    <= conv_acc_pkg::MODE_NONE;
      weight_o  <= '0;
      bias_o    <= '0;
    end else begin
      start_o   <= 1'b0;
      awready_o <= wr_go;  // One-cycle ready pulse
      wready_o  <= wr_go;
      arready_o <= rd_go;
      wr_pend   <= {wr_pend[0], awready_o};
      rd_pend   <= arready_o;
      rd_wait   <= rd_pend && rd_mem;  // Wait out the RAM latency

      if (wr_pend[1]) begin
        bvalid_o <= 1'b1;
      end else if (bready_i) begin
        bvalid_o <= 1'b0;
      end
      if ((rd_pend && !rd_mem) || rd_wait) begin
        rvalid_o <= 1'b1;
      end else if (rready_i) begin
        rvalid_o <= 1'b0;
      end

      // Register writes are ignored during a run
      if (wr_pend[0] && !busy) begin
        case (wr_addr)
          conv_acc_pkg::REG_CTRL: begin
            mode_o <= conv_acc_pkg::conv_acc_mode_t'(wr_data[2:1]);
            if (wr_data[0]) begin
              done <= 1'b0;
            end
            if (start_ok) begin
              start_o <= 1'b1;
              busy    <= 1'b1;
            end
          end
          conv_acc_pkg::REG_WEIGHT: weight_o <= wr_data[DATA_W-1:0];
          conv_acc_pkg::REG_BIAS:   bias_o   <= wr_data[DATA_W-1:0];
          default: ;
        endcase
      end

      if (done_i) begin
        busy <= 1'b0;
        done <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (awready_o) begin
      wr_addr <= awaddr_i;
      wr_data <= wdata_i & wmask;
    end
    if (arready_o) begin
      rd_addr <= araddr_i;
    end
    if (wr_pend[0]) begin
      bresp_o <= (wr_mem && busy) ? RESP_SLVERR : RESP_OKAY;
    end
    if (rd_pend) begin
      rd_err <= rd_mem && busy;
    end
    if (rd_pend && !rd_mem) begin
      rdata_o <= reg_rdata;
      rresp_o <= RESP_OKAY;
    end else if (rd_wait) begin
      rdata_o <= rd_err ? '0 : 32'(host_rdata_i);
      rresp_o <= rd_err ? RESP_SLVERR : RESP_OKAY;
    end
  end

  // A start opens a new busy period from idle
  a_no_start_busy: assert property (@(posedge clk) disable iff (rst_i)
    start_o |-> $rose(busy));

endmodule

`default_nettype wire

// ==== bus_switcher.sv ====
`timescale 1ns/1ps
`default_nettype none

module bus_switcher #(
  parameter int DATA_W = 16,
  parameter int ADDR_W = 6
) (
  input  wire logic                         clk,
  input  wire logic                         rst_i,
  input  wire conv_acc_pkg::conv_acc_mode_t mode_i,
  input  wire logic                         start_i,
  input  wire logic                         done_i,
  input  wire logic                         host_cs_i,
  input  wire logic                         host_we_i,
  input  wire logic                         host_sel_out_i,
  input  wire logic [ADDR_W-1:0]            host_addr_i,
  input  wire logic [DATA_W-1:0]            host_wdata_i,
  output logic      [DATA_W-1:0]            host_rdata_o,
  input  wire logic                         conv_in_cs_i,
  input  wire logic [ADDR_W-1:0]            conv_in_addr_i,
  output logic      [DATA_W-1:0]            conv_in_rdata_o,
  input  wire logic                         conv_out_cs_i,
  input  wire logic [ADDR_W-1:0]            conv_out_addr_i,
  input  wire logic [DATA_W-1:0]            conv_out_wdata_i,
  input  wire logic                         pool_in_cs_i,
  input  wire logic [ADDR_W-1:0]            pool_in_addr_i,
  output logic      [DATA_W-1:0]            pool_in_rdata_o,
  input  wire logic                         pool_out_cs_i,
  input  wire logic [ADDR_W-1:0]            pool_out_addr_i,
  input  wire logic [DATA_W-1:0]            pool_out_wdata_i,
  output logic                              in_cs_o,
  output logic                              in_we_o,
  output logic      [ADDR_W-1:0]            in_addr_o,
  output logic      [DATA_W-1:0]            in_wdata_o,
  input  wire logic [DATA_W-1:0]            in_rdata_i,
  output logic                              out_cs_o,
  output logic                              out_we_o,
  output logic      [ADDR_W-1:0]            out_addr_o,
  output logic      [DATA_W-1:0]            out_wdata_o,
  input  wire logic [DATA_W-1:0]            out_rdata_i,
  output logic                              conv_en_o,
  output logic                              pool_en_o
);

  conv_acc_pkg::conv_acc_mode_t owner;

  // Owner held from start to done, enables registered with it
  always_ff @(posedge clk) begin
    if (rst_i) begin
      owner     <= conv_acc_pkg::MODE_NONE;
      conv_en_o <= 1'b0;
      pool_en_o <= 1'b0;
    end else if (start_i) begin
      owner     <= mode_i;
      conv_en_o <= (mode_i == conv_acc_pkg::MODE_CONV_1X1);
      pool_en_o <= (mode_i == conv_acc_pkg::MODE_MAX_POOL);
    end else if (done_i) begin
      owner     <= conv_acc_pkg::MODE_NONE;
      conv_en_o <= 1'b0;
      pool_en_o <= 1'b0;
    end
  end

  always_comb begin
    host_rdata_o    = '0;
    conv_in_rdata_o = '0;
    pool_in_rdata_o = '0;
    case (owner)
      conv_acc_pkg::MODE_CONV_1X1: begin
        in_cs_o         = conv_in_cs_i;
        in_we_o         = 1'b0;  // Units only read the input map
        in_addr_o       = conv_in_addr_i;
        in_wdata_o      = '0;
        out_cs_o        = conv_out_cs_i;
        out_we_o        = conv_out_cs_i;
        out_addr_o      = conv_out_addr_i;
        out_wdata_o     = conv_out_wdata_i;
        conv_in_rdata_o = in_rdata_i;
      end
      conv_acc_pkg::MODE_MAX_POOL: begin
        in_cs_o         = pool_in_cs_i;
        in_we_o         = 1'b0;
        in_addr_o       = pool_in_addr_i;
        in_wdata_o      = '0;
        out_cs_o        = pool_out_cs_i;
        out_we_o        = pool_out_cs_i;
        out_addr_o      = pool_out_addr_i;
        out_wdata_o     = pool_out_wdata_i;
        pool_in_rdata_o = in_rdata_i;
      end
      default: begin  // Host owns both memories
        in_cs_o      = host_cs_i && !host_sel_out_i;
        in_we_o      = host_we_i;
        in_addr_o    = host_addr_i;
        in_wdata_o   = host_wdata_i;
        out_cs_o     = host_cs_i && host_sel_out_i;
        out_we_o     = host_we_i;
        out_addr_o   = host_addr_i;
        out_wdata_o  = host_wdata_i;
        host_rdata_o = host_sel_out_i ? out_rdata_i : in_rdata_i;
      end
    endcase
  end

  a_one_enable: assert property (@(posedge clk) disable iff (rst_i)
    $onehot0({conv_en_o, pool_en_o}));

endmodule

`default_nettype wire

// ==== conv_1x1_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module conv_1x1_unit #(
  parameter int DATA_W = 16,
  parameter int ADDR_W = 6
) (
  input  wire logic              clk,
  input  wire logic              rst_i,
  input  wire logic              en_i,
  input  wire logic              start_i,
  input  wire logic [DATA_W-1:0] weight_i,
  input  wire logic [DATA_W-1:0] bias_i,
  output logic                   in_cs_o,
  output logic      [ADDR_W-1:0] in_addr_o,
  input  wire logic [DATA_W-1:0] in_rdata_i,
  output logic                   out_cs_o,
  output logic      [ADDR_W-1:0] out_addr_o,
  output logic      [DATA_W-1:0] out_wdata_o,
  output logic                   done_o
);

  conv_acc_pkg::unit_state_t state;
  logic [ADDR_W-1:0] rd_addr;
  logic [ADDR_W-1:0] wr_addr;
  logic              wr_vld;

  assign in_cs_o     = (state == conv_acc_pkg::ST_RUN) && en_i;
  assign in_addr_o   = rd_addr;
  assign out_cs_o    = wr_vld;  // Write one cycle behind the read
  assign out_addr_o  = wr_addr;
  assign out_wdata_o = in_rdata_i * weight_i + bias_i;  // Truncated to DATA_W
  assign done_o      = (state == conv_acc_pkg::ST_DONE);

  always_ff @(posedge clk) begin
    if (rst_i) begin
      state   <= conv_acc_pkg::ST_IDLE;
      rd_addr <= '0;
      wr_vld  <= 1'b0;
    end else begin
      wr_vld <= in_cs_o;
      case (state)
        conv_acc_pkg::ST_IDLE: begin
          if (start_i) begin
            state   <= conv_acc_pkg::ST_RUN;
            rd_addr <= '0;
          end
        end
        conv_acc_pkg::ST_RUN: begin
          if (en_i) begin
            rd_addr <= rd_addr + 1'b1;
            if (&rd_addr) begin
              state <= conv_acc_pkg::ST_DONE;
            end
          end
        end
        default: state <= conv_acc_pkg::ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    wr_addr <= rd_addr;
  end

endmodule

`default_nettype wire

// ==== conv_acc_pkg.sv ====
`default_nettype none

package conv_acc_pkg;

  // Bus owner and unit select
  typedef enum logic [1:0] {
    MODE_NONE     = 2'd0,
    MODE_CONV_1X1 = 2'd1,
    MODE_MAX_POOL = 2'd2
  } conv_acc_mode_t;

  typedef enum logic [1:0] {
    ST_IDLE = 2'd0,
    ST_RUN  = 2'd1,
    ST_DONE = 2'd2
  } unit_state_t;

  // Start in bit 0 and mode in bits 2:1
  localparam logic [11:0] REG_CTRL   = 12'h000;
  localparam logic [11:0] REG_STATUS = 12'h004;  // Busy in bit 0, sticky done in bit 1
  localparam logic [11:0] REG_WEIGHT = 12'h008;
  localparam logic [11:0] REG_BIAS   = 12'h00C;

  // Map windows, one word per 4 bytes
  localparam logic [11:0] IN_BASE    = 12'h100;
  localparam logic [11:0] OUT_BASE   = 12'h200;

endpackage

`default_nettype wire

// ==== conv_acc_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module conv_acc_top #(
  parameter int DATA_W = 16,
  parameter int ADDR_W = 6,
  parameter int FMAP_W = 8
) (
  input  wire logic        clk,
  input  wire logic        rst_i,
  input  wire logic [11:0] awaddr_i,
  input  wire logic        awvalid_i,
  output logic             awready_o,
  input  wire logic [31:0] wdata_i,
  input  wire logic [3:0]  wstrb_i,
  input  wire logic        wvalid_i,
  output logic             wready_o,
  output logic      [1:0]  bresp_o,
  output logic             bvalid_o,
  input  wire logic        bready_i,
  input  wire logic [11:0] araddr_i,
  input  wire logic        arvalid_i,
  output logic             arready_o,
  output logic      [31:0] rdata_o,
  output logic      [1:0]  rresp_o,
  output logic             rvalid_o,
  input  wire logic        rready_i
);

  conv_acc_pkg::conv_acc_mode_t mode;
  logic              start, done, conv_start, pool_start;
  logic [DATA_W-1:0] weight, bias;
  logic              host_cs, host_we, host_sel_out;
  logic [ADDR_W-1:0] host_addr;
  logic [DATA_W-1:0] host_wdata, host_rdata;
  logic              conv_en, conv_done, conv_in_cs, conv_out_cs;
  logic [ADDR_W-1:0] conv_in_addr, conv_out_addr;
  logic [DATA_W-1:0] conv_in_rdata, conv_out_wdata;
  logic              pool_en, pool_done, pool_in_cs, pool_out_cs;
  logic [ADDR_W-1:0] pool_in_addr, pool_out_addr;
  logic [DATA_W-1:0] pool_in_rdata, pool_out_wdata;
  logic              in_cs, in_we, out_cs, out_we;
  logic [ADDR_W-1:0] in_addr, out_addr;
  logic [DATA_W-1:0] in_wdata, in_rdata, out_wdata, out_rdata;

  assign done       = conv_done || pool_done;
  assign conv_start = start && (mode == conv_acc_pkg::MODE_CONV_1X1);  // Only the selected unit
  assign pool_start = start && (mode == conv_acc_pkg::MODE_MAX_POOL);

  acc_ctrl_regs #(.DATA_W(DATA_W), .ADDR_W(ADDR_W)) u_regs (
    .clk, .rst_i, .awaddr_i, .awvalid_i, .awready_o, .wdata_i, .wstrb_i, .wvalid_i, .wready_o,
    .bresp_o, .bvalid_o, .bready_i, .araddr_i, .arvalid_i, .arready_o, .rdata_o, .rresp_o,
    .rvalid_o, .rready_i, .done_i(done), .mode_o(mode), .start_o(start),
    .weight_o(weight), .bias_o(bias),
    .host_cs_o(host_cs), .host_we_o(host_we), .host_sel_out_o(host_sel_out),
    .host_addr_o(host_addr), .host_wdata_o(host_wdata), .host_rdata_i(host_rdata)
  );

  bus_switcher #(.DATA_W(DATA_W), .ADDR_W(ADDR_W)) u_switch (
    .clk, .rst_i, .mode_i(mode), .start_i(start), .done_i(done),
    .host_cs_i(host_cs), .host_we_i(host_we), .host_sel_out_i(host_sel_out),
    .host_addr_i(host_addr), .host_wdata_i(host_wdata), .host_rdata_o(host_rdata),
    .conv_in_cs_i(conv_in_cs), .conv_in_addr_i(conv_in_addr), .conv_in_rdata_o(conv_in_rdata),
    .conv_out_cs_i(conv_out_cs), .conv_out_addr_i(conv_out_addr),
    .conv_out_wdata_i(conv_out_wdata),
    .pool_in_cs_i(pool_in_cs), .pool_in_addr_i(pool_in_addr), .pool_in_rdata_o(pool_in_rdata),
    .pool_out_cs_i(pool_out_cs), .pool_out_addr_i(pool_out_addr),
    .pool_out_wdata_i(pool_out_wdata),
    .in_cs_o(in_cs), .in_we_o(in_we), .in_addr_o(in_addr), .in_wdata_o(in_wdata),
    .in_rdata_i(in_rdata),
    .out_cs_o(out_cs), .out_we_o(out_we), .out_addr_o(out_addr), .out_wdata_o(out_wdata),
    .out_rdata_i(out_rdata),
    .conv_en_o(conv_en), .pool_en_o(pool_en)
  );

  conv_1x1_unit #(.DATA_W(DATA_W), .ADDR_W(ADDR_W)) u_conv (
    .clk, .rst_i, .en_i(conv_en), .start_i(conv_start), .weight_i(weight), .bias_i(bias),
    .in_cs_o(conv_in_cs), .in_addr_o(conv_in_addr), .in_rdata_i(conv_in_rdata),
    .out_cs_o(conv_out_cs), .out_addr_o(conv_out_addr), .out_wdata_o(conv_out_wdata),
    .done_o(conv_done)
  );

  maxpool_unit #(.DATA_W(DATA_W), .ADDR_W(ADDR_W), .FMAP_W(FMAP_W)) u_pool (
    .clk, .rst_i, .en_i(pool_en), .start_i(pool_start),
    .in_cs_o(pool_in_cs), .in_addr_o(pool_in_addr), .in_rdata_i(pool_in_rdata),
    .out_cs_o(pool_out_cs), .out_addr_o(pool_out_addr), .out_wdata_o(pool_out_wdata),
    .done_o(pool_done)
  );

  sp_ram #(.DATA_W(DATA_W), .ADDR_W(ADDR_W)) in_ram (
    .clk, .cs_i(in_cs), .we_i(in_we), .addr_i(in_addr), .wdata_i(in_wdata),
    .rdata_o(in_rdata)
  );

  sp_ram #(.DATA_W(DATA_W), .ADDR_W(ADDR_W)) out_ram (
    .clk, .cs_i(out_cs), .we_i(out_we), .addr_i(out_addr), .wdata_i(out_wdata),
    .rdata_o(out_rdata)
  );

endmodule

`default_nettype wire

// ==== maxpool_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module maxpool_unit #(
  parameter int DATA_W = 16,
  parameter int ADDR_W = 6,
  parameter int FMAP_W = 8
) (
  input  wire logic              clk,
  input  wire logic              rst_i,
  input  wire logic              en_i,
  input  wire logic              start_i,
  output logic                   in_cs_o,
  output logic      [ADDR_W-1:0] in_addr_o,
  input  wire logic [DATA_W-1:0] in_rdata_i,
  output logic                   out_cs_o,
  output logic      [ADDR_W-1:0] out_addr_o,
  output logic      [DATA_W-1:0] out_wdata_o,
  output logic                   done_o
);

  localparam int HALF = FMAP_W / 2;

  conv_acc_pkg::unit_state_t state;
  logic [ADDR_W-1:0] cnt;  // Window index above a 2-bit phase
  logic [ADDR_W-3:0] win;
  logic [ADDR_W-3:0] win_q;
  logic [1:0]        ph_q;
  logic              rd_vld;
  logic [ADDR_W-1:0] row;
  logic [ADDR_W-1:0] col;
  logic [DATA_W-1:0] max_q;
  logic [DATA_W-1:0] cur_max;

  assign win       = cnt[ADDR_W-1:2];
  assign row       = ADDR_W'((win / HALF) * 2 + cnt[1]);
  assign col       = ADDR_W'((win % HALF) * 2 + cnt[0]);
  assign in_cs_o   = (state == conv_acc_pkg::ST_RUN) && en_i;
  assign in_addr_o = ADDR_W'(row * FMAP_W + col);

  // First sample of a window restarts the maximum
  assign cur_max = ((ph_q == 2'd0) || ($signed(in_rdata_i) > $signed(max_q))) ?
                   in_rdata_i : max_q;

  assign out_cs_o    = rd_vld && (ph_q == 2'd3);
  assign out_addr_o  = ADDR_W'(win_q);
  assign out_wdata_o = cur_max;
  assign done_o      = (state == conv_acc_pkg::ST_DONE);

  always_ff @(posedge clk) begin
    if (rst_i) begin
      state  <= conv_acc_pkg::ST_IDLE;
      cnt    <= '0;
      rd_vld <= 1'b0;
    end else begin
      rd_vld <= in_cs_o;
      case (state)
        conv_acc_pkg::ST_IDLE: begin
          if (start_i) begin
            state <= conv_acc_pkg::ST_RUN;
            cnt   <= '0;
          end
        end
        conv_acc_pkg::ST_RUN: begin
          if (en_i) begin
            cnt <= cnt + 1'b1;
            if (&cnt) begin
              state <= conv_acc_pkg::ST_DONE;
            end
          end
        end
        default: state <= conv_acc_pkg::ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    ph_q  <= cnt[1:0];
    win_q <= win;
    if (rd_vld) begin
      max_q <= cur_max;
    end
  end

  a_write_after_four: assert property (@(posedge clk) disable iff (rst_i)
    out_cs_o |-> $past(in_cs_o, 1) && $past(in_cs_o, 2) &&
                 $past(in_cs_o, 3) && $past(in_cs_o, 4));

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
  -f verilog.f --top-module tb_conv_acc -o tb_conv_acc
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/tb_conv_acc > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "Finished with errors" "$LOG"; then
  echo "Simulation FAILED"
  exit 1
fi
echo "Simulation PASSED"
exit 0

// ==== sp_ram.sv ====
`timescale 1ns/1ps
`default_nettype none

module sp_ram #(
  parameter int DATA_W = 16,
  parameter int ADDR_W = 6
) (
  input  wire logic              clk,
  input  wire logic              cs_i,
  input  wire logic              we_i,
  input  wire logic [ADDR_W-1:0] addr_i,
  input  wire logic [DATA_W-1:0] wdata_i,
  output logic      [DATA_W-1:0] rdata_o
);

  logic [DATA_W-1:0] mem [1 << ADDR_W];

  always_ff @(posedge clk) begin
    if (cs_i) begin
      if (we_i) begin
        mem[addr_i] <= wdata_i;
      end else begin
        rdata_o <= mem[addr_i];  // One cycle read latency
      end
    end
  end

endmodule

`default_nettype wire

// ==== tb_conv_acc.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_conv_acc;

  localparam int DATA_W  = 16;
  localparam int ADDR_W  = 6;
  localparam int FMAP_W  = 8;
  localparam int DEPTH   = 1 << ADDR_W;
  localparam int TIMEOUT = 200;  // Cycles per handshake
  localparam logic [1:0] OKAY   = 2'b00;
  localparam logic [1:0] SLVERR = 2'b10;

  logic        clk;
  logic        rst_i;
  logic [11:0] awaddr_i;
  logic        awvalid_i;
  logic        awready_o;
  logic [31:0] wdata_i;
  logic [3:0]  wstrb_i;
  logic        wvalid_i;
  logic        wready_o;
  logic [1:0]  bresp_o;
  logic        bvalid_o;
  logic        bready_i;
  logic [11:0] araddr_i;
  logic        arvalid_i;
  logic        arready_o;
  logic [31:0] rdata_o;
  logic [1:0]  rresp_o;
  logic        rvalid_o;
  logic        rready_i;

  integer            seed;
  int                err_cnt;
  int                chk_cnt;
  int                test_cnt;
  int                test_err;
  string             test_name;
  logic              backpressure;  // Random bready and rready
  logic [DATA_W-1:0] in_model [DEPTH];
  logic [DATA_W-1:0] out_model [DEPTH];
  logic [DATA_W-1:0] weight;
  logic [DATA_W-1:0] bias;
  logic [31:0]       rd_data;
  logic [1:0]        resp;

  conv_acc_top #(.DATA_W(DATA_W), .ADDR_W(ADDR_W), .FMAP_W(FMAP_W)) dut0 (.*);

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    chk_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("ERR t=%0t %s got 0x%0h expected 0x%0h", $time, name, got, exp);
    end
  endtask

  task automatic report_timeout(input string what);
    err_cnt++;
    $display("Timeout at %0t while waiting for %s", $time, what);
  endtask

  function automatic logic [11:0] word_addr(input logic [11:0] base, input int idx);
    return base + 12'(idx * 4);
  endfunction

  task automatic axi_write(input logic [11:0] addr, input logic [31:0] data,
                           output logic [1:0] wr_resp);
    int   n;
    logic ok;
    awaddr_i  <= addr;
    awvalid_i <= 1'b1;
    wdata_i   <= data;
    wvalid_i  <= 1'b1;
    ok = 1'b0;
    n  = 0;
    while (!ok && n < TIMEOUT) begin
      @(posedge clk);
      ok = awready_o && wready_o;
      n++;
    end
    awvalid_i <= 1'b0;
    wvalid_i  <= 1'b0;
    if (!ok) begin
      report_timeout("the write address handshake");
    end
    ok = 1'b0;
    n  = 0;
    while (!ok && n < TIMEOUT) begin
      bready_i <= backpressure ? 1'($random(seed)) : 1'b1;
      @(posedge clk);
      ok = bvalid_o && bready_i;
      n++;
    end
    bready_i <= 1'b0;
    wr_resp = bresp_o;
    if (!ok) begin
      report_timeout("the write response");
    end
  endtask

  task automatic axi_read(input logic [11:0] addr, output logic [31:0] data,
                          output logic [1:0] rd_resp);
    int   n;
    logic ok;
    araddr_i  <= addr;
    arvalid_i <= 1'b1;
    ok = 1'b0;
    n  = 0;
    while (!ok && n < TIMEOUT) begin
      @(posedge clk);
      ok = arready_o;
      n++;
    end
    arvalid_i <= 1'b0;
    if (!ok) begin
      report_timeout("the read address handshake");
    end
    ok = 1'b0;
    n  = 0;
    while (!ok && n < TIMEOUT) begin
      rready_i <= backpressure ? 1'($random(seed)) : 1'b1;
      @(posedge clk);
      ok = rvalid_o && rready_i;
      n++;
    end
    rready_i <= 1'b0;
    data    = rdata_o;
    rd_resp = rresp_o;
    if (!ok) begin
      report_timeout("the read data");
    end
  endtask

  task automatic begin_test(input string name);
    test_cnt++;
    test_name = name;
    test_err  = err_cnt;
  endtask

  task automatic end_test();
    if (err_cnt == test_err) begin
      $display("test %0d %s: ok", test_cnt, test_name);
    end else begin
      $display("test %0d %s: %0d errors", test_cnt, test_name, err_cnt - test_err);
    end
  endtask

  task automatic load_input_map();
    for (int i = 0; i < DEPTH; i++) begin
      in_model[i] = DATA_W'($random(seed));
      axi_write(word_addr(conv_acc_pkg::IN_BASE, i), 32'(in_model[i]), resp);
      check_value("bresp", 32'(resp), 32'(OKAY));
    end
  endtask

  task automatic compare_map(input logic sel_out, input int count);
    logic [11:0] base;
    string       nm;
    base = sel_out ? conv_acc_pkg::OUT_BASE : conv_acc_pkg::IN_BASE;
    nm   = sel_out ? "out_ram" : "in_ram";
    for (int i = 0; i < count; i++) begin
      axi_read(word_addr(base, i), rd_data, resp);
      check_value($sformatf("%s[%0d]", nm, i), rd_data,
                  sel_out ? 32'(out_model[i]) : 32'(in_model[i]));
      check_value("rresp", 32'(resp), 32'(OKAY));
    end
  endtask

  // New weight and bias with the expected conv output
  task automatic set_coeffs();
    logic [31:0] full;
    weight = DATA_W'($random(seed));
    bias   = DATA_W'($random(seed));
    axi_write(conv_acc_pkg::REG_WEIGHT, 32'(weight), resp);
    check_value("weight bresp", 32'(resp), 32'(OKAY));
    axi_write(conv_acc_pkg::REG_BIAS, 32'(bias), resp);
    check_value("bias bresp", 32'(resp), 32'(OKAY));
    for (int i = 0; i < DEPTH; i++) begin
      full         = 32'(in_model[i]) * 32'(weight) + 32'(bias);
      out_model[i] = full[DATA_W-1:0];  // Low 16 bits of the full result
    end
  endtask

  task automatic pool_model();
    logic [DATA_W-1:0] mx;
    logic [DATA_W-1:0] v;
    for (int wr = 0; wr < FMAP_W / 2; wr++) begin
      for (int wc = 0; wc < FMAP_W / 2; wc++) begin
        mx = in_model[2 * wr * FMAP_W + 2 * wc];
        for (int k = 1; k < 4; k++) begin
          v = in_model[(2 * wr + k / 2) * FMAP_W + 2 * wc + k % 2];
          if ($signed(v) > $signed(mx)) begin
            mx = v;
          end
        end
        out_model[wr * (FMAP_W / 2) + wc] = mx;
      end
    end
  endtask

  task automatic start_run(input conv_acc_pkg::conv_acc_mode_t mode);
    axi_write(conv_acc_pkg::REG_CTRL, 32'({mode, 1'b1}), resp);
    check_value("ctrl bresp", 32'(resp), 32'(OKAY));
  endtask

  task automatic wait_done();
    int   n;
    logic seen;
    seen = 1'b0;
    n    = 0;
    while (!seen && n < 100) begin
      axi_read(conv_acc_pkg::REG_STATUS, rd_data, resp);
      seen = rd_data[1];
      n++;
    end
    if (!seen) begin
      report_timeout("done in STATUS");
    end
    check_value("status busy", 32'(rd_data[0]), 32'd0);
  endtask

  initial begin
    seed         = 32'hd915_61c0;
    err_cnt      = 0;
    chk_cnt      = 0;
    test_cnt     = 0;
    backpressure = 1'b0;
    rst_i        = 1'b1;
    awaddr_i     = '0;
    awvalid_i    = 1'b0;
    wdata_i      = '0;
    wstrb_i      = 4'hf;
    wvalid_i     = 1'b0;
    bready_i     = 1'b0;
    araddr_i     = '0;
    arvalid_i    = 1'b0;
    rready_i     = 1'b0;
    repeat (2) @(posedge clk);
    rst_i <= 1'b0;
    @(posedge clk);

    begin_test("reset state and input map");
    axi_read(conv_acc_pkg::REG_STATUS, rd_data, resp);
    check_value("status", rd_data, 32'd0);
    axi_read(conv_acc_pkg::REG_CTRL, rd_data, resp);
    check_value("ctrl mode", 32'(rd_data[2:1]), 32'(conv_acc_pkg::MODE_NONE));
    load_input_map();
    compare_map(1'b0, DEPTH);
    end_test();

    begin_test("conv 1x1 run");
    set_coeffs();
    start_run(conv_acc_pkg::MODE_CONV_1X1);
    wait_done();
    compare_map(1'b1, DEPTH);
    end_test();

    begin_test("max pool run");
    load_input_map();
    pool_model();
    start_run(conv_acc_pkg::MODE_MAX_POOL);
    wait_done();
    compare_map(1'b1, DEPTH);  // Upper words still hold conv results
    end_test();

    begin_test("host access while busy");
    set_coeffs();
    start_run(conv_acc_pkg::MODE_CONV_1X1);
    axi_write(word_addr(conv_acc_pkg::IN_BASE, 5), {16'h0, ~in_model[5]}, resp);
    check_value("busy bresp", 32'(resp), 32'(SLVERR));
    axi_read(word_addr(conv_acc_pkg::IN_BASE, 9), rd_data, resp);
    check_value("busy rdata", rd_data, 32'd0);
    check_value("busy rresp", 32'(resp), 32'(SLVERR));
    axi_read(conv_acc_pkg::REG_STATUS, rd_data, resp);
    check_value("status busy", 32'(rd_data[0]), 32'd1);
    wait_done();
    compare_map(1'b0, DEPTH);
    compare_map(1'b1, DEPTH);
    end_test();

    begin_test("start without a mode");
    start_run(conv_acc_pkg::MODE_NONE);
    repeat (4) begin
      axi_read(conv_acc_pkg::REG_STATUS, rd_data, resp);
      check_value("status busy", 32'(rd_data[0]), 32'd0);
    end
    compare_map(1'b1, DEPTH);
    end_test();

    begin_test("random back-pressure");
    backpressure = 1'b1;
    load_input_map();
    set_coeffs();
    start_run(conv_acc_pkg::MODE_CONV_1X1);
    wait_done();
    compare_map(1'b0, DEPTH);
    compare_map(1'b1, DEPTH);
    backpressure = 1'b0;
    end_test();

    $display("tests %0d, checks %0d, errors %0d", test_cnt, chk_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== verilog.f ====
conv_acc_pkg.sv
sp_ram.sv
acc_ctrl_regs.sv
bus_switcher.sv
conv_1x1_unit.sv
maxpool_unit.sv
conv_acc_top.sv
tb_conv_acc.sv
